// File: list.f
+incdir+verif
verilog/dmem_pkg.sv
verilog/store_data_translator.sv
verilog/load_data_translator.sv
verilog/byte_lane_ram.sv
verilog/load_stall_ctrl.sv
verilog/data_mem.sv
verif/data_mem_tb.sv

// File: verif/data_mem_tb_table.svh
//////////////////////////////
// data memory directed table
//////////////////////////////
`ifndef DATA_MEM_TB_TABLE_SVH
`define DATA_MEM_TB_TABLE_SVH

// columns: kind, op, address (word index on boot rows), data, expected load result
task automatic fill_table();
    // preload through the boot port
    add_row(kind_boot, dmem_pkg::op_lw,  32'd0,          32'h8123_45f6, 32'h0);
    add_row(kind_boot, dmem_pkg::op_lw,  32'd1,          32'h7f80_01ff, 32'h0);
    add_row(kind_boot, dmem_pkg::op_lw,  32'd2,          32'h0000_0000, 32'h0);
    add_row(kind_boot, dmem_pkg::op_lw,  32'd3,          32'hdead_beef, 32'h0);
    add_row(kind_boot, dmem_pkg::op_lw,  32'd63,         32'h5a5a_a5a5, 32'h0);

    // boot words read back unchanged
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0000, 32'h0, 32'h8123_45f6);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0004, 32'h0, 32'h7f80_01ff);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'h0000_0000);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_000c, 32'h0, 32'hdead_beef);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_00fc, 32'h0, 32'h5a5a_a5a5);

    // byte and half loads from word 0, bytes 81 23 45 f6
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0000, 32'h0, 32'hffff_ff81);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h0000_0000, 32'h0, 32'h0000_0081);
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0001, 32'h0, 32'h0000_0023);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h0000_0001, 32'h0, 32'h0000_0023);
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0002, 32'h0, 32'h0000_0045);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h0000_0002, 32'h0, 32'h0000_0045);
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0003, 32'h0, 32'hffff_fff6);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h0000_0003, 32'h0, 32'h0000_00f6);
    add_row(kind_req,  dmem_pkg::op_lh,  32'h0000_0000, 32'h0, 32'hffff_8123);
    add_row(kind_req,  dmem_pkg::op_lhu, 32'h0000_0000, 32'h0, 32'h0000_8123);
    add_row(kind_req,  dmem_pkg::op_lh,  32'h0000_0002, 32'h0, 32'h0000_45f6);
    add_row(kind_req,  dmem_pkg::op_lhu, 32'h0000_0002, 32'h0, 32'h0000_45f6);

    // word 1, bytes 7f 80 01 ff
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0004, 32'h0, 32'h0000_007f);
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0005, 32'h0, 32'hffff_ff80);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h0000_0005, 32'h0, 32'h0000_0080);
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0007, 32'h0, 32'hffff_ffff);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h0000_0007, 32'h0, 32'h0000_00ff);
    add_row(kind_req,  dmem_pkg::op_lh,  32'h0000_0004, 32'h0, 32'h0000_7f80);
    add_row(kind_req,  dmem_pkg::op_lhu, 32'h0000_0004, 32'h0, 32'h0000_7f80);
    add_row(kind_req,  dmem_pkg::op_lh,  32'h0000_0006, 32'h0, 32'h0000_01ff);

    // word 3, negative halves
    add_row(kind_req,  dmem_pkg::op_lh,  32'h0000_000c, 32'h0, 32'hffff_dead);
    add_row(kind_req,  dmem_pkg::op_lh,  32'h0000_000e, 32'h0, 32'hffff_beef);
    add_row(kind_req,  dmem_pkg::op_lhu, 32'h0000_000e, 32'h0, 32'h0000_beef);

    // lane merges into word 2, upper data bits must be ignored
    add_row(kind_req,  dmem_pkg::op_sb,  32'h0000_0008, 32'h0000_0011, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'h1100_0000);
    add_row(kind_req,  dmem_pkg::op_sb,  32'h0000_0009, 32'hffff_ff22, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'h1122_0000);
    add_row(kind_req,  dmem_pkg::op_sb,  32'h0000_000a, 32'h0000_0033, 32'h0);
    add_row(kind_req,  dmem_pkg::op_sb,  32'h0000_000b, 32'h0000_0044, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'h1122_3344);
    add_row(kind_req,  dmem_pkg::op_sh,  32'h0000_0008, 32'habcd_5566, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'h5566_3344);
    add_row(kind_req,  dmem_pkg::op_sh,  32'h0000_000a, 32'h0000_7788, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'h5566_7788);
    add_row(kind_req,  dmem_pkg::op_sw,  32'h0000_0008, 32'hcafe_f00d, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0008, 32'h0, 32'hcafe_f00d);
    add_row(kind_req,  dmem_pkg::op_lb,  32'h0000_0008, 32'h0, 32'hffff_ffca);
    add_row(kind_req,  dmem_pkg::op_lhu, 32'h0000_000a, 32'h0, 32'h0000_f00d);
    add_row(kind_req,  dmem_pkg::op_sb,  32'h0000_00ff, 32'h0000_0000, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_00fc, 32'h0, 32'h5a5a_a500);

    // I/O region stores are dropped
    add_row(kind_req,  dmem_pkg::op_sw,  32'h8000_000c, 32'h1234_5678, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_000c, 32'h0, 32'hdead_beef);
    add_row(kind_req,  dmem_pkg::op_sb,  32'h8000_0001, 32'h0000_0099, 32'h0);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h0000_0000, 32'h0, 32'h8123_45f6);
    add_row(kind_req,  dmem_pkg::op_lw,  32'h8000_0004, 32'h0, 32'h7f80_01ff);
    add_row(kind_req,  dmem_pkg::op_lbu, 32'h8000_0003, 32'h0, 32'h0000_00f6);
endtask

`endif

// File: verif/data_mem_tb.sv
//////////////////////////////
// data memory testbench
//////////////////////////////
`timescale 1ns/10ps

module data_mem_tb;

    localparam int mem_words_log2 = 6;
    localparam int mem_depth      = 1 << mem_words_log2;
    localparam int clk_period     = 20;
    localparam int reset_cycles   = 8;
    localparam int rand_requests  = 40;
    localparam int kind_boot      = 0;
    localparam int kind_req       = 1;

    logic                      clk;
    logic                      rst;
    logic                      en;
    logic                      stalled;
    logic [31:0]               d_writedata;
    logic [31:0]               d_address;
    dmem_pkg::mem_op_e         op;
    logic [31:0]               d_loadresult;
    logic [mem_words_log2-1:0] boot_daddr;
    logic [31:0]               boot_ddata;
    logic                      boot_dwe;

    int                row_kind [$];
    dmem_pkg::mem_op_e row_op [$];
    logic [31:0]       row_addr [$];
    logic [31:0]       row_data [$];
    logic [31:0]       row_expect [$];

    logic [31:0] shadow [0:mem_depth-1];  // reference copy for the random phase
    logic [31:0] rng_state;
    int          error_count;
    int          tests_run;
    int          tests_ok;
    int          cycle_count;
    int          cycle_limit;

    task automatic add_row(input int kind, input dmem_pkg::mem_op_e rop,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] expect_val);
        row_kind.push_back(kind);
        row_op.push_back(rop);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_expect.push_back(expect_val);
    endtask

    `include "data_mem_tb_table.svh"

    data_mem #(.mem_words_log2(mem_words_log2)) DUT
    (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .stalled      (stalled),
        .d_writedata  (d_writedata),
        .d_address    (d_address),
        .op           (op),
        .d_loadresult (d_loadresult),
        .boot_daddr   (boot_daddr),
        .boot_ddata   (boot_ddata),
        .boot_dwe     (boot_dwe)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_store_op(input dmem_pkg::mem_op_e sop);
        case (sop)
            dmem_pkg::op_sw, dmem_pkg::op_sh, dmem_pkg::op_sb: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic dmem_pkg::mem_op_e pick_op(input logic [2:0] sel);
        case (sel)
            3'd0: return dmem_pkg::op_lw;
            3'd1: return dmem_pkg::op_lhu;
            3'd2: return dmem_pkg::op_lbu;
            3'd3: return dmem_pkg::op_lh;
            3'd4: return dmem_pkg::op_lb;
            3'd5: return dmem_pkg::op_sw;
            3'd6: return dmem_pkg::op_sh;
            default: return dmem_pkg::op_sb;
        endcase
    endfunction

    // offset 0 is the most significant byte
    function automatic logic [31:0] merge_store(input logic [31:0] old_word,
                                                input dmem_pkg::mem_op_e sop,
                                                input logic [1:0] off, input logic [31:0] data);
        logic [31:0] mask;
        logic [31:0] placed;
        int          shift_bits;
        mask   = 32'hffff_ffff;
        placed = data;
        if (sop == dmem_pkg::op_sb)
        begin
            shift_bits = 8 * (3 - int'(off));
            mask       = 32'h0000_00ff << shift_bits;
            placed     = (data & 32'h0000_00ff) << shift_bits;
        end
        else if (sop == dmem_pkg::op_sh)
        begin
            shift_bits = off[1] ? 0 : 16;
            mask       = 32'h0000_ffff << shift_bits;
            placed     = (data & 32'h0000_ffff) << shift_bits;
        end
        return (old_word & ~mask) | placed;
    endfunction

    function automatic logic [31:0] extract_load(input logic [31:0] word,
                                                 input dmem_pkg::mem_op_e lop,
                                                 input logic [1:0] off);
        logic [31:0] shifted;
        logic [31:0] result;
        result = word;
        if (lop == dmem_pkg::op_lb || lop == dmem_pkg::op_lbu)
        begin
            shifted = word >> (8 * (3 - int'(off)));
            result  = {24'h0, shifted[7:0]};
            if (lop == dmem_pkg::op_lb && shifted[7])
                result[31:8] = '1;
        end
        else if (lop == dmem_pkg::op_lh || lop == dmem_pkg::op_lhu)
        begin
            shifted = off[1] ? word : word >> 16;
            result  = {16'h0, shifted[15:0]};
            if (lop == dmem_pkg::op_lh && shifted[15])
                result[31:16] = '1;
        end
        return result;
    endfunction

    task automatic boot_write(input int idx, input logic [31:0] word);
        @(posedge clk);
        #2;
        en         = 1'b0;
        boot_dwe   = 1'b1;
        boot_daddr = idx[mem_words_log2-1:0];
        boot_ddata = word;
    endtask

    task automatic issue_store(input dmem_pkg::mem_op_e sop, input logic [31:0] addr,
                               input logic [31:0] data);
        @(posedge clk);
        #2;
        boot_dwe    = 1'b0;
        en          = 1'b1;
        op          = sop;
        d_address   = addr;
        d_writedata = data;
        @(negedge clk);
        assert (stalled === 1'b0)
        else
        begin
            $display("Fail stalled expected %h actual %h", 1'b0, stalled);
            error_count++;
        end
    endtask

    // request held until the result cycle has been sampled
    task automatic issue_load(input dmem_pkg::mem_op_e lop, input logic [31:0] addr,
                              input logic [31:0] expect_val);
        int stall_cycles;
        @(posedge clk);
        #2;
        boot_dwe  = 1'b0;
        en        = 1'b1;
        op        = lop;
        d_address = addr;
        stall_cycles = 0;
        @(negedge clk);
        while (stalled === 1'b1)
        begin
            stall_cycles++;
            @(negedge clk);
        end
        assert (stall_cycles == 1)
        else
        begin
            $display("load stall lasted %0d cycles instead of one", stall_cycles);
            error_count++;
        end
        assert (d_loadresult === expect_val)
        else
        begin
            $display("Fail d_loadresult expected %h actual %h", expect_val, d_loadresult);
            error_count++;
        end
    endtask

    task automatic report_test(input string what, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
        begin
            tests_ok++;
            $display("test %0d %s ok", tests_run, what);
        end
        else
            $display("test %0d %s error", tests_run, what);
    endtask

    // watchdog
    initial
    begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run went past %0d clock cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        int                errors_before;
        int                word_idx;
        logic [1:0]        off;
        logic              io_region;
        logic [31:0]       addr;
        logic [31:0]       data;
        dmem_pkg::mem_op_e rop;

        rst         = 1'b1;
        en          = 1'b0;
        op          = dmem_pkg::op_lw;
        d_address   = '0;
        d_writedata = '0;
        boot_daddr  = '0;
        boot_ddata  = '0;
        boot_dwe    = 1'b0;
        error_count = 0;
        tests_run   = 0;
        tests_ok    = 0;
        rng_state   = 32'h160ac775;
        fill_table();
        // four cycles per row and per fill word plus reset and margin
        cycle_limit = 4 * (row_kind.size() + rand_requests + mem_depth) + reset_cycles + 40;

        repeat (reset_cycles) @(posedge clk);
        #2;
        rst       = 1'b0;
        en        = 1'b1;  // load in the first cycle, only an idle FSM takes it
        op        = dmem_pkg::op_lw;
        d_address = '0;
        @(negedge clk);
        errors_before = error_count;
        assert (stalled === 1'b1)
        else
        begin
            $display("Fail stalled expected %h actual %h", 1'b1, stalled);
            error_count++;
        end
        @(negedge clk);
        assert (stalled === 1'b0)
        else
        begin
            $display("Fail stalled expected %h actual %h", 1'b0, stalled);
            error_count++;
        end
        report_test("idle after reset", errors_before);

        for (int i = 0; i < row_kind.size(); i++)
        begin
            errors_before = error_count;
            if (row_kind[i] == kind_boot)
                boot_write(row_addr[i], row_data[i]);
            else if (is_store_op(row_op[i]))
                issue_store(row_op[i], row_addr[i], row_data[i]);
            else
                issue_load(row_op[i], row_addr[i], row_expect[i]);
            report_test($sformatf("row %0d op %h addr %h", i, row_op[i], row_addr[i]),
                        errors_before);
        end

        // known contents everywhere before random traffic
        for (int w = 0; w < mem_depth; w++)
        begin
            rng_state = lcg_next(rng_state);
            shadow[w] = rng_state;
            boot_write(w, rng_state);
        end

        for (int n = 0; n < rand_requests; n++)
        begin
            errors_before = error_count;
            rng_state = lcg_next(rng_state);
            rop       = pick_op(rng_state[31:29]);
            word_idx  = rng_state[27:22];
            off       = rng_state[21:20];
            io_region = (rng_state[18:16] == 3'd0);  // about one in eight
            if (rop == dmem_pkg::op_lh || rop == dmem_pkg::op_lhu || rop == dmem_pkg::op_sh)
                off[0] = 1'b0;
            else if (rop == dmem_pkg::op_lw || rop == dmem_pkg::op_sw)
                off = 2'b00;
            addr = {io_region, 23'd0, word_idx[5:0], off};
            rng_state = lcg_next(rng_state);
            data = rng_state;
            if (is_store_op(rop))
            begin
                issue_store(rop, addr, data);
                if (!io_region)
                    shadow[word_idx] = merge_store(shadow[word_idx], rop, off, data);
            end
            else
                issue_load(rop, addr, extract_load(shadow[word_idx], rop, off));
            report_test($sformatf("random %0d op %h addr %h", n, rop, addr), errors_before);
        end

        @(posedge clk);
        #2;
        en       = 1'b0;
        boot_dwe = 1'b0;
        repeat (2) @(posedge clk);
        $display("tests run %0d, ok %0d, failing %0d, check errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: verilog/byte_lane_ram.sv
//////////////////////////////
// dual-port word RAM
//////////////////////////////
`timescale 1ns/10ps

module byte_lane_ram
#(
    parameter int mem_words_log2 = 6
)
(
    input  logic                            clk,

    // processor port, byte writes
    input  logic                            wr_en,
    input  logic [dmem_pkg::byte_lanes-1:0] byte_ena,
    input  logic [mem_words_log2-1:0]       addr_a,
    input  logic [dmem_pkg::word_width-1:0] data_a,
    output logic [dmem_pkg::word_width-1:0] q_a,

    // boot port, whole words only
    input  logic                            boot_we,
    input  logic [mem_words_log2-1:0]       boot_addr,
    input  logic [dmem_pkg::word_width-1:0] boot_data
);

    localparam int mem_depth = 1 << mem_words_log2;
    localparam int lane_w    = dmem_pkg::lane_width;

    logic [dmem_pkg::word_width-1:0] mem [0:mem_depth-1];
    logic [mem_words_log2-1:0]       addr_a_q;

    // read address captured every edge
    always_ff @(posedge clk)
    begin
        addr_a_q <= addr_a;
    end

    assign q_a = mem[addr_a_q];  // one cycle behind the address

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int i = 0; i < dmem_pkg::byte_lanes; i++)
            begin
                if (byte_ena[i])
                    mem[addr_a][i*lane_w +: lane_w] <= data_a[i*lane_w +: lane_w];
            end
        end
        // boot write comes last so it wins a same-word clash
        if (boot_we)
            mem[boot_addr] <= boot_data;
    end

endmodule

// File: verilog/data_mem.sv
//////////////////////////////
// data memory top level
//////////////////////////////
`timescale 1ns/10ps

module data_mem
#(
    parameter int mem_words_log2 = 6   // 64 words by default
)
(
    input  logic                            clk,
    input  logic                            rst,

    // processor request
    input  logic                            en,
    output logic                            stalled,
    input  logic [dmem_pkg::word_width-1:0] d_writedata,
    input  logic [31:0]                     d_address,   // byte address
    input  dmem_pkg::mem_op_e               op,
    output logic [dmem_pkg::word_width-1:0] d_loadresult,

    // boot preload, word index
    input  logic [mem_words_log2-1:0]       boot_daddr,
    input  logic [dmem_pkg::word_width-1:0] boot_ddata,
    input  logic                            boot_dwe
);

    logic [3:0]                      op_bits;
    logic                            is_store;
    logic                            is_signed;
    dmem_pkg::mem_size_e             access_size;

    logic [mem_words_log2-1:0]       word_addr;
    logic [1:0]                      addr_low_q;
    logic                            ram_we;
    logic                            load_req;

    logic [dmem_pkg::byte_lanes-1:0] byte_ena;
    logic [dmem_pkg::word_width-1:0] write_lanes;
    logic [dmem_pkg::word_width-1:0] read_word;

    // opcode fields {store, sign, size}
    assign op_bits     = op;
    assign is_store    = op_bits[3];
    assign is_signed   = op_bits[2];
    assign access_size = dmem_pkg::mem_size_e'(op_bits[1:0]);

    assign word_addr = d_address[mem_words_log2+1:2];

    // I/O region (bit 31) never reaches the RAM
    assign ram_we   = en && is_store && !d_address[31];
    assign load_req = en && !is_store;

    // byte offset kept for the wait cycle
    always_ff @(posedge clk)
    begin
        if (en)
            addr_low_q <= d_address[1:0];
    end

    store_data_translator u_store_xlate
    (
        .write_data  (d_writedata),
        .addr_low    (d_address[1:0]),
        .store_size  (access_size),
        .byte_ena    (byte_ena),
        .write_lanes (write_lanes)
    );

    byte_lane_ram
    #(
        .mem_words_log2 (mem_words_log2)
    )
    u_ram
    (
        .clk       (clk),
        .wr_en     (ram_we),
        .byte_ena  (byte_ena),
        .addr_a    (word_addr),
        .data_a    (write_lanes),
        .q_a       (read_word),
        .boot_we   (boot_dwe),
        .boot_addr (boot_daddr),
        .boot_data (boot_ddata)
    );

    // op is still held in the wait cycle, so size and sign are current
    load_data_translator u_load_xlate
    (
        .read_word   (read_word),
        .addr_low    (addr_low_q),
        .load_size   (access_size),
        .sign_ext    (is_signed),
        .load_result (d_loadresult)
    );

    load_stall_ctrl u_stall
    (
        .clk      (clk),
        .rst      (rst),
        .load_req (load_req),
        .stalled  (stalled)
    );

endmodule

// File: verilog/dmem_pkg.sv
//////////////////////////////
// data memory shared types
//////////////////////////////

package dmem_pkg;

    // data path geometry
    localparam int word_width = 32;
    localparam int byte_lanes = 4;
    localparam int lane_width = word_width / byte_lanes;  // 8 bits per lane

    // opcode bits are {store, sign, size1, size0}
    typedef enum logic [3:0] {
        op_lw  = 4'd0,
        op_lhu = 4'd1,
        op_lbu = 4'd3,
        op_lh  = 4'd5,
        op_lb  = 4'd7,
        op_sw  = 4'd8,   // store, sign bit ignored
        op_sh  = 4'd9,
        op_sb  = 4'd11
    } mem_op_e;

    // low two opcode bits, code 2 is unused
    typedef enum logic [1:0] {
        size_word = 2'd0,
        size_half = 2'd1,
        size_byte = 2'd3
    } mem_size_e;

endpackage

// File: verilog/load_data_translator.sv
//////////////////////////////
// load extract and extend
//////////////////////////////
`timescale 1ns/10ps

module load_data_translator
(
    input  logic [dmem_pkg::word_width-1:0] read_word,
    input  logic [1:0]                      addr_low,   // latched with the request
    input  dmem_pkg::mem_size_e             load_size,
    input  logic                            sign_ext,
    output logic [dmem_pkg::word_width-1:0] load_result
);

    localparam int byte_w = dmem_pkg::lane_width;
    localparam int half_w = 2 * dmem_pkg::lane_width;

    logic [1:0]        lane;
    logic              half_hi;
    logic [byte_w-1:0] byte_val;
    logic [half_w-1:0] half_val;

    assign lane    = ~addr_low;
    assign half_hi = ~addr_low[1];

    // big-endian lane pick
    assign byte_val = read_word[lane*byte_w +: byte_w];
    assign half_val = read_word[half_hi*half_w +: half_w];

    always_comb
    begin
        case (load_size)
            dmem_pkg::size_byte:
                load_result = {{(dmem_pkg::word_width-byte_w){sign_ext & byte_val[byte_w-1]}},
                               byte_val};
            dmem_pkg::size_half:
                load_result = {{(dmem_pkg::word_width-half_w){sign_ext & half_val[half_w-1]}},
                               half_val};
            default:
                load_result = read_word;  // lw passes through
        endcase
    end

endmodule

// File: verilog/load_stall_ctrl.sv
//////////////////////////////
// load stall FSM
//////////////////////////////
`timescale 1ns/10ps

module load_stall_ctrl
(
    input  logic clk,
    input  logic rst,
    input  logic load_req,  // en with a load op
    output logic stalled
);

    typedef enum logic {
        st_idle,
        st_wait   // RAM output valid in this cycle
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
                if (load_req)
                    state_nxt = st_wait;
            default:
                state_nxt = st_idle;  // held request is served, release
        endcase
    end

    // raised in the request cycle only
    assign stalled = (state == st_idle) && load_req;

endmodule

// File: verilog/store_data_translator.sv
//////////////////////////////
// store lane placement
//////////////////////////////
`timescale 1ns/10ps

module store_data_translator
(
    input  logic [dmem_pkg::word_width-1:0] write_data,  // value in low bits
    input  logic [1:0]                      addr_low,
    input  dmem_pkg::mem_size_e             store_size,
    output logic [dmem_pkg::byte_lanes-1:0] byte_ena,
    output logic [dmem_pkg::word_width-1:0] write_lanes
);

    localparam int byte_w = dmem_pkg::lane_width;
    localparam int half_w = 2 * dmem_pkg::lane_width;

    logic [1:0] lane;  // offset 0 is the top lane
    logic       half_hi;

    assign lane    = ~addr_low;      // same as 3 - addr_low
    assign half_hi = ~addr_low[1];   // offset 0 selects the upper half

    always_comb
    begin
        byte_ena    = '0;
        write_lanes = '0;
        case (store_size)
            dmem_pkg::size_byte:
            begin
                byte_ena[lane] = 1'b1;
                write_lanes[lane*byte_w +: byte_w] = write_data[byte_w-1:0];
            end
            dmem_pkg::size_half:
            begin
                // two adjacent lanes
                byte_ena[{half_hi, 1'b1}] = 1'b1;
                byte_ena[{half_hi, 1'b0}] = 1'b1;
                write_lanes[half_hi*half_w +: half_w] = write_data[half_w-1:0];
            end
            default:
            begin
                byte_ena    = '1;   // full word
                write_lanes = write_data;
            end
        endcase
    end

endmodule
